/* logic/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	//////////////////////////////
	// datapath widths
	//////////////////////////////
	localparam int XLEN   = 32; // address and data width
	localparam int ILEN   = 32; // one uncompressed instruction
	localparam int WAYS   = 2;  // instructions fetched per cycle
	localparam int LINE_W = 64; // memory hands back a doubleword per way

	typedef logic [XLEN-1:0]   addr_t;     // byte address
	typedef logic [ILEN-1:0]   inst_t;     // raw instruction word
	typedef logic [LINE_W-1:0] line_t;     // aligned memory return
	typedef logic [WAYS-1:0]   way_mask_t; // one bit per way, way 0 in bit 0

	//////////////////////////////
	// fetch constants
	//////////////////////////////
	// byte distance between neighbouring ways
	localparam addr_t INST_BYTES = addr_t'(ILEN / 8);

	// first fetch after reset
	localparam addr_t RESET_PC = '0;

endpackage : fetch_pkg

`default_nettype wire

/* logic/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

	//////////////////////////////
	// instruction fields
	//////////////////////////////
	localparam int OPCODE_W = 7;  // inst[6:0]
	localparam int IMM_W    = 32; // immediates after sign extension

	typedef logic [OPCODE_W-1:0] opcode_t;
	typedef logic [IMM_W-1:0]    imm_t;   // sign extended, bit 0 always zero for jumps

	//////////////////////////////
	// major opcodes
	//////////////////////////////
	// only the control transfers that fetch can resolve by itself
	localparam opcode_t OP_JAL    = 7'b1101111; // J-type, always taken
	localparam opcode_t OP_BRANCH = 7'b1100011; // B-type, beq/bne/blt/bge/bltu/bgeu

	// J-type immediate layout
	//   imm[20]    inst[31]
	//   imm[10:1]  inst[30:21]
	//   imm[11]    inst[20]
	//   imm[19:12] inst[19:12]
	// B-type immediate layout
	//   imm[12]    inst[31]
	//   imm[10:5]  inst[30:25]
	//   imm[4:1]   inst[11:8]
	//   imm[11]    inst[7]

endpackage : rv_isa_pkg

`default_nettype wire

/* logic/if_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module if_stage import fetch_pkg::*; (
	input  wire               clock,
	input  wire               reset,
	input  wire               stall,          // back-pressure from decode
	input  wire               redirect_valid, // late correction from the back end
	input  wire addr_t        redirect_pc,
	input  wire addr_t        pc_predicted,   // from next_pc_select
	input  wire line_t     [WAYS-1:0] imem_data,
	input  wire way_mask_t    imem_valid,
	output addr_t     [WAYS-1:0] imem_addr,
	output addr_t     [WAYS-1:0] fetch_pc,
	output inst_t     [WAYS-1:0] fetch_inst,
	output logic              fetch_load,     // capture the group downstream
	output logic              fetch_clear     // drop whatever downstream holds
);

	addr_t pc_reg; // pc of way 0
	logic  all_valid;

	//////////////////////////////
	// per-way address and word pick
	//////////////////////////////
	always_comb begin
		for (int i = 0; i < WAYS; i++) begin
			fetch_pc[i]  = pc_reg + INST_BYTES * addr_t'(i);
			imem_addr[i] = {fetch_pc[i][XLEN-1:3], 3'b000}; // doubleword aligned
			// bit 2 picks the upper word of the doubleword
			fetch_inst[i] = fetch_pc[i][2] ? imem_data[i][ILEN +: ILEN]
			                               : imem_data[i][0 +: ILEN];
		end
	end

	//////////////////////////////
	// advance / clear control
	//////////////////////////////
	assign all_valid = &imem_valid; // whole group or nothing

	// redirect wins over everything, stall only holds
	assign fetch_load  = ~stall & all_valid & ~redirect_valid;
	assign fetch_clear = redirect_valid | (~stall & ~all_valid); // bubble on a miss

	// pc register
	always_ff @(posedge clock) begin
		if (reset) begin
			pc_reg <= RESET_PC;
		end else if (redirect_valid) begin
			pc_reg <= redirect_pc;  // taken even during a stall
		end else if (fetch_load) begin
			pc_reg <= pc_predicted;
		end
		// otherwise hold, retry same group
	end

endmodule : if_stage

`default_nettype wire

/* logic/branch_predecode.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predecode
	import fetch_pkg::*;
	import rv_isa_pkg::*;
(
	input  wire addr_t [WAYS-1:0] fetch_pc,
	input  wire inst_t [WAYS-1:0] fetch_inst,
	output way_mask_t             way_is_jump, // predicted taken, per way
	output addr_t      [WAYS-1:0] way_target   // pc + imm, meaningful when jumping
);

	opcode_t   [WAYS-1:0] opcode;
	imm_t      [WAYS-1:0] imm_j;  // J-type offset
	imm_t      [WAYS-1:0] imm_b;  // B-type offset
	way_mask_t            is_jal;
	way_mask_t            is_branch;

	//////////////////////////////
	// opcode and immediates
	//////////////////////////////
	always_comb begin
		for (int i = 0; i < WAYS; i++) begin
			opcode[i]    = fetch_inst[i][OPCODE_W-1:0];
			is_jal[i]    = (opcode[i] == OP_JAL);
			is_branch[i] = (opcode[i] == OP_BRANCH);

			// scattered J-type fields, 21-bit offset
			imm_j[i] = {{12{fetch_inst[i][31]}},
			            fetch_inst[i][19:12],
			            fetch_inst[i][20],
			            fetch_inst[i][30:21],
			            1'b0};

			// scattered B-type fields, 13-bit offset
			imm_b[i] = {{20{fetch_inst[i][31]}},
			            fetch_inst[i][7],
			            fetch_inst[i][30:25],
			            fetch_inst[i][11:8],
			            1'b0};
		end
	end

	//////////////////////////////
	// static prediction and target
	//////////////////////////////
	always_comb begin
		for (int i = 0; i < WAYS; i++) begin
			// jal always, branch only when it points backwards (loop closing)
			way_is_jump[i] = is_jal[i] | (is_branch[i] & imm_b[i][IMM_W-1]);

			// pc relative target, jal offset if jal else branch offset
			if (is_jal[i]) begin
				way_target[i] = fetch_pc[i] + addr_t'(imm_j[i]);
			end else begin
				way_target[i] = fetch_pc[i] + addr_t'(imm_b[i]); // don't care if not a branch
			end
		end
	end

endmodule : branch_predecode

`default_nettype wire

/* logic/next_pc_select.sv */
`timescale 1ns/1ps
`default_nettype none

module next_pc_select import fetch_pkg::*; (
	input  wire addr_t     [WAYS-1:0] fetch_pc,
	input  wire way_mask_t            way_is_jump,
	input  wire addr_t     [WAYS-1:0] way_target,
	output addr_t                     pc_predicted, // next fetch pc
	output way_mask_t                 keep_mask,    // ways that survive the group
	output way_mask_t                 way_taken,    // the one way that redirects fetch
	output addr_t          [WAYS-1:0] way_npc       // next pc seen by each way
);

	logic found; // an older way already jumps

	//////////////////////////////
	// priority search, way 0 first
	//////////////////////////////
	always_comb begin
		found        = 1'b0;
		pc_predicted = fetch_pc[0] + addr_t'(WAYS) * INST_BYTES; // fall through, pc + 8
		for (int i = 0; i < WAYS; i++) begin
			keep_mask[i] = ~found;                  // younger than a jump dies
			way_taken[i] = way_is_jump[i] & ~found; // only the first jump counts
			if (way_is_jump[i] && !found) begin
				pc_predicted = way_target[i];
			end
			found = found | way_is_jump[i];
		end
	end

	// per-way next pc, handed down with the instruction
	always_comb begin
		for (int i = 0; i < WAYS; i++) begin
			if (way_is_jump[i]) begin
				way_npc[i] = way_target[i];
			end else begin
				way_npc[i] = fetch_pc[i] + INST_BYTES; // sequential
			end
		end
	end

endmodule : next_pc_select

`default_nettype wire

/* logic/fetch_result.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_result import fetch_pkg::*; (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       fetch_load,
	input  wire                       fetch_clear,
	input  wire addr_t     [WAYS-1:0] fetch_pc,
	input  wire inst_t     [WAYS-1:0] fetch_inst,
	input  wire way_mask_t            keep_mask,
	input  wire way_mask_t            way_taken,
	input  wire addr_t     [WAYS-1:0] way_npc,
	output way_mask_t                 out_valid,
	output addr_t          [WAYS-1:0] out_pc,
	output addr_t          [WAYS-1:0] out_npc,
	output inst_t          [WAYS-1:0] out_inst,
	output way_mask_t                 out_taken
);

	//////////////////////////////
	// valid and taken bits
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || fetch_clear) begin
			out_valid <= '0;
			out_taken <= '0; // taken means nothing without valid
		end else if (fetch_load) begin
			out_valid <= keep_mask; // ways behind a jump are killed here
			out_taken <= way_taken;
		end
		// no load and no clear, stall holds the packet
	end

	//////////////////////////////
	// payload
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (fetch_load) begin
			out_pc   <= fetch_pc;
			out_npc  <= way_npc;
			out_inst <= fetch_inst;
		end
	end

endmodule : fetch_result

`default_nettype wire

/* logic/fetch_front.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_front import fetch_pkg::*; (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       stall,
	input  wire                       redirect_valid,
	input  wire addr_t                redirect_pc,
	input  wire line_t     [WAYS-1:0] imem_data,
	input  wire way_mask_t            imem_valid,
	output addr_t          [WAYS-1:0] imem_addr,
	output way_mask_t                 out_valid,
	output addr_t          [WAYS-1:0] out_pc,
	output addr_t          [WAYS-1:0] out_npc,
	output inst_t          [WAYS-1:0] out_inst,
	output way_mask_t                 out_taken
);

	// fetch group, combinational within the cycle
	addr_t     [WAYS-1:0] fetch_pc;
	inst_t     [WAYS-1:0] fetch_inst;
	logic                 fetch_load;
	logic                 fetch_clear;

	// predecode to prediction
	way_mask_t            way_is_jump;
	addr_t     [WAYS-1:0] way_target;

	// prediction results
	addr_t                pc_predicted; // loops back into the pc register
	way_mask_t            keep_mask;
	way_mask_t            way_taken;
	addr_t     [WAYS-1:0] way_npc;

	if_stage u_if_stage (
		.clock          (clock),
		.reset          (reset),
		.stall          (stall),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.pc_predicted   (pc_predicted),
		.imem_data      (imem_data),
		.imem_valid     (imem_valid),
		.imem_addr      (imem_addr),
		.fetch_pc       (fetch_pc),
		.fetch_inst     (fetch_inst),
		.fetch_load     (fetch_load),
		.fetch_clear    (fetch_clear)
	);

	branch_predecode u_branch_predecode (
		.fetch_pc    (fetch_pc),
		.fetch_inst  (fetch_inst),
		.way_is_jump (way_is_jump),
		.way_target  (way_target)
	);

	next_pc_select u_next_pc_select (
		.fetch_pc     (fetch_pc),
		.way_is_jump  (way_is_jump),
		.way_target   (way_target),
		.pc_predicted (pc_predicted),
		.keep_mask    (keep_mask),
		.way_taken    (way_taken),
		.way_npc      (way_npc)
	);

	fetch_result u_fetch_result (
		.clock       (clock),
		.reset       (reset),
		.fetch_load  (fetch_load),
		.fetch_clear (fetch_clear),
		.fetch_pc    (fetch_pc),
		.fetch_inst  (fetch_inst),
		.keep_mask   (keep_mask),
		.way_taken   (way_taken),
		.way_npc     (way_npc),
		.out_valid   (out_valid),
		.out_pc      (out_pc),
		.out_npc     (out_npc),
		.out_inst    (out_inst),
		.out_taken   (out_taken)
	);

endmodule : fetch_front

`default_nettype wire

/* include/fetch_vectors.svh */
// row arguments are stall, redirect_valid, redirect_pc and drop imem_valid
// followed by expected out_valid, out_pc[0], out_npc[0], out_npc[1] and out_taken
`ifndef FETCH_VECTORS_SVH
`define FETCH_VECTORS_SVH

task automatic load_vectors();
	// sequential groups advance by 8
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b11, 32'h00, 32'h04, 32'h08, 2'b00);
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b11, 32'h08, 32'h0c, 32'h10, 2'b00);
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b01, 32'h10, 32'h40, 32'h00, 2'b01); // jal way 0
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b11, 32'h40, 32'h44, 32'h20, 2'b10); // back branch
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b11, 32'h20, 32'h24, 32'h28, 2'b00); // fwd branch
	// stall holds everything
	add_vec(1'b1, 1'b0, 32'h00, 1'b0, 2'b11, 32'h20, 32'h24, 32'h28, 2'b00);
	add_vec(1'b1, 1'b0, 32'h00, 1'b0, 2'b11, 32'h20, 32'h24, 32'h28, 2'b00);
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b11, 32'h28, 32'h2c, 32'h30, 2'b00);
	add_vec(1'b0, 1'b0, 32'h00, 1'b1, 2'b00, 32'h00, 32'h00, 32'h00, 2'b00); // imem miss
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b11, 32'h30, 32'h34, 32'h38, 2'b00);
	// plain redirect then a redirect under stall
	add_vec(1'b0, 1'b1, 32'h18, 1'b0, 2'b00, 32'h00, 32'h00, 32'h00, 2'b00);
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b11, 32'h18, 32'h1c, 32'h20, 2'b00);
	add_vec(1'b1, 1'b1, 32'h10, 1'b0, 2'b00, 32'h00, 32'h00, 32'h00, 2'b00);
	add_vec(1'b1, 1'b0, 32'h00, 1'b0, 2'b00, 32'h00, 32'h00, 32'h00, 2'b00);
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b01, 32'h10, 32'h40, 32'h00, 2'b01);
	add_vec(1'b0, 1'b0, 32'h00, 1'b1, 2'b00, 32'h00, 32'h00, 32'h00, 2'b00); // pc held
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b11, 32'h40, 32'h44, 32'h20, 2'b10);
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b11, 32'h20, 32'h24, 32'h28, 2'b00);
	// group straddling two doublewords
	add_vec(1'b0, 1'b1, 32'h0c, 1'b0, 2'b00, 32'h00, 32'h00, 32'h00, 2'b00);
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b11, 32'h0c, 32'h10, 32'h40, 2'b10); // jal way 1
	add_vec(1'b0, 1'b0, 32'h00, 1'b0, 2'b11, 32'h40, 32'h44, 32'h20, 2'b10);
endtask

`endif

/* verif/fetch_front_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_front_tb import fetch_pkg::*, rv_isa_pkg::*; ();

	localparam int      MAX_VEC   = 32;
	localparam int      MEM_WORDS = 64;         // 256 bytes of program space
	localparam opcode_t OP_IMM    = 7'b0010011; // filler opcode that never transfers control

	logic                 clock;
	logic                 reset;
	logic                 stall;
	logic                 redirect_valid;
	addr_t                redirect_pc;
	line_t     [WAYS-1:0] imem_data;
	way_mask_t            imem_valid;
	addr_t     [WAYS-1:0] imem_addr;
	way_mask_t            out_valid;
	addr_t     [WAYS-1:0] out_pc;
	addr_t     [WAYS-1:0] out_npc;
	inst_t     [WAYS-1:0] out_inst;
	way_mask_t            out_taken;

	inst_t       mem [0:MEM_WORDS-1]; // word array behind imem
	logic [31:0] lcg_state;

	// stimulus and expected columns with one entry per cycle
	logic      vec_stall    [0:MAX_VEC-1];
	logic      vec_redirect [0:MAX_VEC-1];
	addr_t     vec_rpc      [0:MAX_VEC-1];
	logic      vec_drop     [0:MAX_VEC-1];
	way_mask_t vec_valid    [0:MAX_VEC-1];
	addr_t     vec_pc0      [0:MAX_VEC-1];
	addr_t     vec_npc0     [0:MAX_VEC-1];
	addr_t     vec_npc1     [0:MAX_VEC-1];
	way_mask_t vec_taken    [0:MAX_VEC-1];
	int        vec_count   = 0;
	int        error_count = 0;
	int        check_count = 0;
	int        cycle_count = 0;

	fetch_front u_fetch_front (
		.clock          (clock),
		.reset          (reset),
		.stall          (stall),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.imem_data      (imem_data),
		.imem_valid     (imem_valid),
		.imem_addr      (imem_addr),
		.out_valid      (out_valid),
		.out_pc         (out_pc),
		.out_npc        (out_npc),
		.out_inst       (out_inst),
		.out_taken      (out_taken)
	);

	//////////////////////////////
	// memory model
	//////////////////////////////
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			// aligned doubleword with the upper word at +4
			imem_data[w] = {mem[{imem_addr[w][7:3], 1'b1}], mem[{imem_addr[w][7:3], 1'b0}]};
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic load_program();
		logic [31:0] r;
		for (int i = 0; i < MEM_WORDS; i++) begin
			r      = next_random() ^ (32'(i) * 32'h9e3779b1); // spread over the whole index
			mem[i] = {r[31:7], OP_IMM};
		end
		mem[4]  = {25'h0060001, OP_JAL};    // jal x1 +48 at 0x10 jumps to 0x40
		mem[8]  = {25'h0000010, OP_BRANCH}; // beq +16 at 0x20 points forward and stays untaken
		mem[17] = {25'h1f8001d, OP_BRANCH}; // beq -36 at 0x44 loops back to 0x20
	endtask

	task automatic add_vec(input logic s, input logic r, input addr_t rpc, input logic d,
		input way_mask_t v, input addr_t pc0, input addr_t npc0, input addr_t npc1,
		input way_mask_t t);
		vec_stall[vec_count]    = s;
		vec_redirect[vec_count] = r;
		vec_rpc[vec_count]      = rpc;
		vec_drop[vec_count]     = d;
		vec_valid[vec_count]    = v;
		vec_pc0[vec_count]      = pc0;
		vec_npc0[vec_count]     = npc0;
		vec_npc1[vec_count]     = npc1;
		vec_taken[vec_count]    = t;
		vec_count++;
	endtask

	`include "fetch_vectors.svh"

	//////////////////////////////
	// compare tasks
	//////////////////////////////
	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_mask(input string name, input way_mask_t exp, input way_mask_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_inst(input string name, input inst_t exp, input inst_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic apply_inputs(input int k);
		logic [31:0] r;
		stall          = vec_stall[k];
		redirect_valid = vec_redirect[k];
		redirect_pc    = vec_rpc[k];
		if (vec_drop[k]) begin
			r          = next_random();
			imem_valid = ~(way_mask_t'(1) << r[16]); // one way misses
		end else begin
			imem_valid = '1;
		end
	endtask

	// memory address per way for a group that is about to be captured
	task automatic check_fetch_addr(input int k);
		addr_t pc1;
		pc1 = vec_pc0[k] + INST_BYTES;
		check_addr("imem_addr[0]", vec_pc0[k] & ~addr_t'(7), imem_addr[0]); // low 3 bits clear
		check_addr("imem_addr[1]", pc1 & ~addr_t'(7), imem_addr[1]);
	endtask

	task automatic check_outputs(input int k);
		addr_t pc1;
		pc1 = vec_pc0[k] + INST_BYTES;
		check_mask("out_valid", vec_valid[k], out_valid);
		check_mask("out_taken", vec_taken[k], out_taken);
		if (vec_valid[k][0]) begin // payload only matters under valid
			check_addr("out_pc[0]", vec_pc0[k], out_pc[0]);
			check_addr("out_npc[0]", vec_npc0[k], out_npc[0]);
			check_inst("out_inst[0]", mem[vec_pc0[k][7:2]], out_inst[0]);
		end
		if (vec_valid[k][1]) begin
			check_addr("out_pc[1]", pc1, out_pc[1]);
			check_addr("out_npc[1]", vec_npc1[k], out_npc[1]);
			check_inst("out_inst[1]", mem[pc1[7:2]], out_inst[1]);
		end
	endtask

	//////////////////////////////
	// clock, watchdog, sequence
	//////////////////////////////
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > vec_count + 20) begin // reset plus table plus margin
			$display("timeout: run did not finish within %0d cycles", vec_count + 20);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		reset          = 1'b1;
		stall          = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		imem_valid     = '1;
		lcg_state      = 32'hf41d;
		load_program();
		load_vectors();
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
		check_mask("out_valid", '0, out_valid); // nothing fetched yet
		for (int k = 0; k < vec_count; k++) begin
			apply_inputs(k);
			if (!vec_stall[k] && !vec_redirect[k] && !vec_drop[k]) begin
				check_fetch_addr(k); // pc register already settled
			end
			@(posedge clock);
			#1; // outputs settled after the edge
			check_outputs(k);
		end
		$display("errors: %0d of %0d checks", error_count, check_count);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule : fetch_front_tb

`default_nettype wire

/* compile.f */
+incdir+include
logic/fetch_pkg.sv
logic/rv_isa_pkg.sv
logic/if_stage.sv
logic/branch_predecode.sv
logic/next_pc_select.sv
logic/fetch_result.sv
logic/fetch_front.sv
verif/fetch_front_tb.sv

/* Bender.yml */
package:
  name: fetch_front

sources:
  - files:
      - logic/fetch_pkg.sv
      - logic/rv_isa_pkg.sv
      - logic/if_stage.sv
      - logic/branch_predecode.sv
      - logic/next_pc_select.sv
      - logic/fetch_result.sv
      - logic/fetch_front.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/fetch_front_tb.sv
